// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = rv_core_tb
FILELIST  = rv_core.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::XLEN-1:0]       if_pc_i,
    input  logic [rv_pkg::XLEN-1:0]       if_instr_i,
    input  logic                          ex_mem_read_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic                          wb_reg_write_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
    output logic                          reg_write_o, alu_src_o, branch_o,
    output logic                          mem_read_o, mem_write_o, mem_to_reg_o,
    output rv_pkg::alu_op_e               alu_op_o,
    output logic [rv_pkg::XLEN-1:0]       imm_o, rdata1_o, rdata2_o, pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o, rs2_o, rd_o,
    output logic                          load_use_stall_o
);

    logic [rv_pkg::XLEN-1:0] regs [0:31];
    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_i_type, imm_s_type, imm_b_type;
    logic                    supported;
    logic                    writes_rd;

    assign opcode = rv_pkg::opcode_e'(if_instr_i[6:0]);
    assign funct3 = if_instr_i[14:12];
    assign funct7 = if_instr_i[31:25];
    assign rd_o   = if_instr_i[11:7];
    assign rs1_o  = if_instr_i[19:15];
    assign rs2_o  = if_instr_i[24:20];
    assign pc_o   = if_pc_i;

    assign imm_i_type = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_s_type = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
    assign imm_b_type = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                         if_instr_i[30:25], if_instr_i[11:8], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        supported    = 1'b1;
        writes_rd    = 1'b0;
        alu_src_o    = 1'b0;
        branch_o     = 1'b0;
        mem_read_o   = 1'b0;
        mem_write_o  = 1'b0;
        mem_to_reg_o = 1'b0;
        alu_op_o     = rv_pkg::alu_add;
        imm_o        = imm_i_type;
        case (opcode)
            rv_pkg::op_reg: begin
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op_o = rv_pkg::alu_add;
                    {7'b0100000, 3'b000}: alu_op_o = rv_pkg::alu_sub;
                    {7'b0000000, 3'b111}: alu_op_o = rv_pkg::alu_and;
                    {7'b0000000, 3'b110}: alu_op_o = rv_pkg::alu_or;
                    {7'b0000000, 3'b100}: alu_op_o = rv_pkg::alu_xor;
                    {7'b0000000, 3'b010}: alu_op_o = rv_pkg::alu_slt;
                    default: supported = 1'b0;
                endcase
            end
            rv_pkg::op_imm: begin
                // addi only
                writes_rd = 1'b1;
                alu_src_o = 1'b1;
                supported = (funct3 == 3'b000);
            end
            rv_pkg::op_load: begin
                writes_rd    = 1'b1;
                alu_src_o    = 1'b1;
                mem_read_o   = 1'b1;
                mem_to_reg_o = 1'b1;
                supported    = (funct3 == 3'b010);
            end
            rv_pkg::op_store: begin
                alu_src_o   = 1'b1;
                mem_write_o = 1'b1;
                imm_o       = imm_s_type;
                supported   = (funct3 == 3'b010);
            end
            rv_pkg::op_branch: begin
                branch_o  = 1'b1;
                imm_o     = imm_b_type;
                supported = (funct3 == 3'b000);
            end
            default: supported = 1'b0;
        endcase

        // Bubble on unknown words and on a load-use stall
        if (!supported || load_use_stall_o) begin
            writes_rd    = 1'b0;
            alu_src_o    = 1'b0;
            branch_o     = 1'b0;
            mem_read_o   = 1'b0;
            mem_write_o  = 1'b0;
            mem_to_reg_o = 1'b0;
            alu_op_o     = rv_pkg::alu_add;
        end
        reg_write_o = writes_rd && (rd_o != '0);
    end

    // Load in EX feeding the instruction now in ID
    assign load_use_stall_o = ex_mem_read_i && (ex_rd_i != '0) &&
                              ((ex_rd_i == rs1_o) || (ex_rd_i == rs2_o));

    ////////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_reg_write_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Write-first, same-cycle writeback is seen by the read
    assign rdata1_o = (rs1_o == '0) ? '0 :
                      (wb_reg_write_i && (wb_rd_i == rs1_o)) ? wb_data_i : regs[rs1_o];
    assign rdata2_o = (rs2_o == '0) ? '0 :
                      (wb_reg_write_i && (wb_rd_i == rs2_o)) ? wb_data_i : regs[rs2_o];

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_reg_write_i, ex_alu_src_i, ex_branch_i,
    input  logic                          ex_mem_read_i, ex_mem_write_i, ex_mem_to_reg_i,
    input  rv_pkg::alu_op_e               ex_alu_op_i,
    input  logic [rv_pkg::XLEN-1:0]       ex_imm_i, ex_rdata1_i, ex_rdata2_i, ex_pc_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1_i, ex_rs2_i, ex_rd_i,
    input  logic                          wb_reg_write_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
    output logic                          branch_taken_o,
    output logic [rv_pkg::XLEN-1:0]       branch_target_o,
    output logic                          mem_reg_write_o, mem_read_o,
    output logic                          mem_write_o, mem_to_reg_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] mem_rd_o,
    output logic [rv_pkg::XLEN-1:0]       mem_alu_result_o, mem_store_data_o
);

    logic                    fwd_mem_a, fwd_mem_b, fwd_wb_a, fwd_wb_b;
    logic [rv_pkg::XLEN-1:0] op_a, op_b, alu_b, alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding, EX/MEM first, x0 never
    ////////////////////////////////////////////////////////////////////////////
    assign fwd_mem_a = mem_reg_write_o && (mem_rd_o != '0) && (mem_rd_o == ex_rs1_i);
    assign fwd_mem_b = mem_reg_write_o && (mem_rd_o != '0) && (mem_rd_o == ex_rs2_i);
    assign fwd_wb_a  = wb_reg_write_i && (wb_rd_i != '0) && (wb_rd_i == ex_rs1_i);
    assign fwd_wb_b  = wb_reg_write_i && (wb_rd_i != '0) && (wb_rd_i == ex_rs2_i);

    assign op_a  = fwd_mem_a ? mem_alu_result_o : fwd_wb_a ? wb_data_i : ex_rdata1_i;
    assign op_b  = fwd_mem_b ? mem_alu_result_o : fwd_wb_b ? wb_data_i : ex_rdata2_i;
    assign alu_b = ex_alu_src_i ? ex_imm_i : op_b;

    always_comb begin
        alu_result = '0;
        case (ex_alu_op_i)
            rv_pkg::alu_add: alu_result = op_a + alu_b;
            rv_pkg::alu_sub: alu_result = op_a - alu_b;
            rv_pkg::alu_and: alu_result = op_a & alu_b;
            rv_pkg::alu_or:  alu_result = op_a | alu_b;
            rv_pkg::alu_xor: alu_result = op_a ^ alu_b;
            rv_pkg::alu_slt: alu_result[0] = $signed(op_a) < $signed(alu_b);
            default:         alu_result = op_a + alu_b;
        endcase
    end

    // beq resolves here, target is pc plus B immediate
    assign branch_taken_o  = ex_branch_i && (op_a == op_b);
    assign branch_target_o = ex_pc_i + ex_imm_i;

    ////////////////////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_n) begin
            mem_reg_write_o <= 1'b0;
            mem_read_o      <= 1'b0;
            mem_write_o     <= 1'b0;
            mem_to_reg_o    <= 1'b0;
        end else begin
            mem_reg_write_o <= ex_reg_write_i;
            mem_read_o      <= ex_mem_read_i;
            mem_write_o     <= ex_mem_write_i;
            mem_to_reg_o    <= ex_mem_to_reg_i;
        end
    end

    // Store data takes the forwarded rs2
    always_ff @(posedge clk) begin
        mem_rd_o         <= ex_rd_i;
        mem_alu_result_o <= alu_result;
        mem_store_data_o <= op_b;
    end

endmodule

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic                          reg_write_i, alu_src_i, branch_i,
    input  logic                          mem_read_i, mem_write_i, mem_to_reg_i,
    input  rv_pkg::alu_op_e               alu_op_i,
    input  logic [rv_pkg::XLEN-1:0]       imm_i, rdata1_i, rdata2_i, pc_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i, rs2_i, rd_i,
    output logic                          reg_write_o, alu_src_o, branch_o,
    output logic                          mem_read_o, mem_write_o, mem_to_reg_o,
    output rv_pkg::alu_op_e               alu_op_o,
    output logic [rv_pkg::XLEN-1:0]       imm_o, rdata1_o, rdata2_o, pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o, rs2_o, rd_o
);

    // Controls, cleared to a bubble on reset or a taken branch
    always_ff @(posedge clk) begin
        if (rst_n || flush_i) begin
            reg_write_o  <= 1'b0;
            alu_src_o    <= 1'b0;
            branch_o     <= 1'b0;
            mem_read_o   <= 1'b0;
            mem_write_o  <= 1'b0;
            mem_to_reg_o <= 1'b0;
            alu_op_o     <= rv_pkg::alu_add;
        end else begin
            reg_write_o  <= reg_write_i;
            alu_src_o    <= alu_src_i;
            branch_o     <= branch_i;
            mem_read_o   <= mem_read_i;
            mem_write_o  <= mem_write_i;
            mem_to_reg_o <= mem_to_reg_i;
            alu_op_o     <= alu_op_i;
        end
    end

    // Operands and indices
    always_ff @(posedge clk) begin
        imm_o    <= imm_i;
        rdata1_o <= rdata1_i;
        rdata2_o <= rdata2_i;
        pc_o     <= pc_i;
        rs1_o    <= rs1_i;
        rs2_o    <= rs2_i;
        rd_o     <= rd_i;
    end

endmodule

// ==== hdl/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch #(
    parameter int IMEM_AW = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    imem_we_i,
    input  logic [IMEM_AW-1:0]      imem_addr_i,
    input  logic [rv_pkg::XLEN-1:0] imem_wdata_i,
    input  logic                    load_use_stall_i,
    input  logic                    branch_taken_i,
    input  logic [rv_pkg::XLEN-1:0] branch_target_i,
    output logic [rv_pkg::XLEN-1:0] if_pc_o,
    output logic [rv_pkg::XLEN-1:0] if_instr_o
);

    localparam logic [rv_pkg::XLEN-1:0] PC_STEP = 4;

    logic [rv_pkg::XLEN-1:0] imem [0:2**IMEM_AW-1];
    logic [rv_pkg::XLEN-1:0] pc_q;
    logic [rv_pkg::XLEN-1:0] fetch_word;

    // Program load, only while the core sits in reset
    always_ff @(posedge clk) begin
        if (rst_n && imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    // Word index from the byte PC
    assign fetch_word = imem[pc_q[IMEM_AW+1:2]];

    // Taken branch wins over a stall
    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_q <= '0;
        end else if (branch_taken_i) begin
            pc_q <= branch_target_i;
        end else if (!load_use_stall_i) begin
            pc_q <= pc_q + PC_STEP;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////////////////////
    // All-zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst_n || branch_taken_i) begin
            if_instr_o <= '0;
        end else if (!load_use_stall_i) begin
            if_instr_o <= fetch_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!load_use_stall_i) begin
            if_pc_o <= pc_q;
        end
    end

endmodule

// ==== hdl/mem_writeback.sv ====
`timescale 1ns/1ps

module mem_writeback #(
    parameter int DMEM_AW = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_reg_write_i, mem_read_i,
    input  logic                          mem_write_i, mem_to_reg_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] mem_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       mem_alu_result_i, mem_store_data_i,
    output logic                          wb_reg_write_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

    logic [rv_pkg::XLEN-1:0] dmem [0:2**DMEM_AW-1];
    logic [DMEM_AW-1:0]      word_addr;
    logic [rv_pkg::XLEN-1:0] load_data;

    // Word index above the byte offset
    assign word_addr = mem_alu_result_i[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (mem_write_i) begin
            dmem[word_addr] <= mem_store_data_i;
        end
    end

    assign load_data = mem_read_i ? dmem[word_addr] : '0;

    ////////////////////////////////////////////////////////////////////////////
    // MEM/WB register, also the retire trace
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_n) begin
            wb_reg_write_o <= 1'b0;
        end else begin
            wb_reg_write_o <= mem_reg_write_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= mem_rd_i;
        wb_data_o <= mem_to_reg_i ? load_data : mem_alu_result_i;
    end

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          imem_we_i,
    input  logic [IMEM_AW-1:0]            imem_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       imem_wdata_i,
    output logic                          wb_valid_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

    // Fetch and hazard control
    logic [rv_pkg::XLEN-1:0]       if_pc, if_instr, branch_target;
    logic                          load_use_stall, branch_taken;

    // Decode outputs
    logic                          id_reg_write, id_alu_src, id_branch;
    logic                          id_mem_read, id_mem_write, id_mem_to_reg;
    rv_pkg::alu_op_e               id_alu_op;
    logic [rv_pkg::XLEN-1:0]       id_imm, id_rdata1, id_rdata2, id_pc;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs1, id_rs2, id_rd;

    // ID/EX outputs
    logic                          ex_reg_write, ex_alu_src, ex_branch;
    logic                          ex_mem_read, ex_mem_write, ex_mem_to_reg;
    rv_pkg::alu_op_e               ex_alu_op;
    logic [rv_pkg::XLEN-1:0]       ex_imm, ex_rdata1, ex_rdata2, ex_pc;
    logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;

    // EX/MEM and MEM/WB
    logic                          mem_reg_write, mem_read, mem_write, mem_to_reg;
    logic [rv_pkg::REG_ADDR_W-1:0] mem_rd, wb_rd;
    logic [rv_pkg::XLEN-1:0]       mem_alu_result, mem_store_data, wb_data;
    logic                          wb_reg_write;

    instr_fetch #(.IMEM_AW(IMEM_AW)) u_fetch (
        .clk(clk), .rst_n(rst_n),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .load_use_stall_i(load_use_stall), .branch_taken_i(branch_taken),
        .branch_target_i(branch_target),
        .if_pc_o(if_pc), .if_instr_o(if_instr)
    );

    decode_unit u_decode (
        .clk(clk), .rst_n(rst_n), .if_pc_i(if_pc), .if_instr_i(if_instr),
        .ex_mem_read_i(ex_mem_read), .ex_rd_i(ex_rd),
        .wb_reg_write_i(wb_reg_write), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .reg_write_o(id_reg_write), .alu_src_o(id_alu_src), .branch_o(id_branch),
        .mem_read_o(id_mem_read), .mem_write_o(id_mem_write), .mem_to_reg_o(id_mem_to_reg),
        .alu_op_o(id_alu_op), .imm_o(id_imm), .rdata1_o(id_rdata1), .rdata2_o(id_rdata2),
        .rs1_o(id_rs1), .rs2_o(id_rs2), .rd_o(id_rd), .pc_o(id_pc),
        .load_use_stall_o(load_use_stall)
    );

    id_ex_reg u_id_ex (
        .clk(clk), .rst_n(rst_n), .flush_i(branch_taken),
        .reg_write_i(id_reg_write), .alu_src_i(id_alu_src), .branch_i(id_branch),
        .mem_read_i(id_mem_read), .mem_write_i(id_mem_write), .mem_to_reg_i(id_mem_to_reg),
        .alu_op_i(id_alu_op), .imm_i(id_imm), .rdata1_i(id_rdata1), .rdata2_i(id_rdata2),
        .pc_i(id_pc), .rs1_i(id_rs1), .rs2_i(id_rs2), .rd_i(id_rd),
        .reg_write_o(ex_reg_write), .alu_src_o(ex_alu_src), .branch_o(ex_branch),
        .mem_read_o(ex_mem_read), .mem_write_o(ex_mem_write), .mem_to_reg_o(ex_mem_to_reg),
        .alu_op_o(ex_alu_op), .imm_o(ex_imm), .rdata1_o(ex_rdata1), .rdata2_o(ex_rdata2),
        .pc_o(ex_pc), .rs1_o(ex_rs1), .rs2_o(ex_rs2), .rd_o(ex_rd)
    );

    execute_unit u_execute (
        .clk(clk), .rst_n(rst_n),
        .ex_reg_write_i(ex_reg_write), .ex_alu_src_i(ex_alu_src), .ex_branch_i(ex_branch),
        .ex_mem_read_i(ex_mem_read), .ex_mem_write_i(ex_mem_write),
        .ex_mem_to_reg_i(ex_mem_to_reg), .ex_alu_op_i(ex_alu_op),
        .ex_imm_i(ex_imm), .ex_rdata1_i(ex_rdata1), .ex_rdata2_i(ex_rdata2), .ex_pc_i(ex_pc),
        .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd),
        .wb_reg_write_i(wb_reg_write), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .mem_reg_write_o(mem_reg_write), .mem_read_o(mem_read),
        .mem_write_o(mem_write), .mem_to_reg_o(mem_to_reg), .mem_rd_o(mem_rd),
        .mem_alu_result_o(mem_alu_result), .mem_store_data_o(mem_store_data)
    );

    mem_writeback #(.DMEM_AW(DMEM_AW)) u_mem_wb (
        .clk(clk), .rst_n(rst_n),
        .mem_reg_write_i(mem_reg_write), .mem_read_i(mem_read),
        .mem_write_i(mem_write), .mem_to_reg_i(mem_to_reg), .mem_rd_i(mem_rd),
        .mem_alu_result_i(mem_alu_result), .mem_store_data_i(mem_store_data),
        .wb_reg_write_o(wb_reg_write), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

    // Retire trace
    assign wb_valid_o = wb_reg_write;
    assign wb_rd_o    = wb_rd;
    assign wb_data_o  = wb_data;

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    // Data word and register index widths
    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes of the supported RV32I subset
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    // ALU operations selected by decode
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5
    } alu_op_e;

endpackage

// ==== rv_core.f ====
hdl/rv_pkg.sv
hdl/instr_fetch.sv
hdl/decode_unit.sv
hdl/id_ex_reg.sv
hdl/execute_unit.sv
hdl/mem_writeback.sv
hdl/rv_core.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    localparam int IMEM_AW      = 8;
    localparam int DMEM_AW      = 8;
    localparam int IMEM_DEPTH   = 2**IMEM_AW;
    localparam int RESET_CYCLES = 3;

    logic               clk;
    logic               rst_n;
    logic               imem_we_i;
    logic [IMEM_AW-1:0] imem_addr_i;
    logic [31:0]        imem_wdata_i;
    logic               wb_valid_o;
    logic [4:0]         wb_rd_o;
    logic [31:0]        wb_data_o;

    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] model_mem [int];
    logic [15:0] lfsr_q;
    int          budget;
    int          cycles;

    rv_core #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random source and instruction encoders
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return int'(v);
    endfunction

    // Kind selects 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt
    function automatic logic [31:0] reg_op(input int kind, input int rd, input int rs1,
                                           input int rs2);
        logic [9:0] f;
        case (kind)
            1:       f = 10'b0100000_000;
            2:       f = 10'b0000000_111;
            3:       f = 10'b0000000_110;
            4:       f = 10'b0000000_100;
            5:       f = 10'b0000000_010;
            default: f = 10'b0000000_000;
        endcase
        return {f[9:3], rs2[4:0], rs1[4:0], f[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] add_imm(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_eq(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
                7'b1100011};
    endfunction

    task automatic check_equal(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", test, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction-level RV32I model that lists the register writes in order
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_model();
        logic [31:0] regs_m [0:31];
        logic [31:0] w, a, b, imm_i, imm_s, imm_b, res, addr;
        logic        wr;
        int          pc;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        model_mem.delete();
        exp_rd.delete();
        exp_data.delete();
        pc = 0;
        steps = 0;
        while (pc >= 0 && pc < 4 * prog.size() && steps < 1000) begin
            w     = prog[pc / 4];
            a     = regs_m[w[19:15]];
            b     = regs_m[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            wr    = 1'b0;
            res   = '0;
            case (w[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_111: res = a & b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         wr = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    wr  = (w[14:12] == 3'b000);
                    res = a + imm_i;
                end
                7'b0000011: begin
                    addr = a + imm_i;
                    wr   = (w[14:12] == 3'b010);
                    res  = model_mem.exists(int'(addr[31:2])) ? model_mem[int'(addr[31:2])] : '0;
                end
                7'b0100011: begin
                    addr = a + imm_s;
                    if (w[14:12] == 3'b010) begin
                        model_mem[int'(addr[31:2])] = b;
                    end
                end
                7'b1100011: begin
                    // Taken beq target less the step added below
                    if (w[14:12] == 3'b000 && a == b) begin
                        pc = pc + int'(imm_b) - 4;
                    end
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                regs_m[w[11:7]] = res;
                exp_rd.push_back(w[11:7]);
                exp_data.push_back(res);
            end
            pc = pc + 4;
            steps++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Load the program, release reset and compare the retire trace
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_program(input string name);
        int idx;
        budget = budget + 64 * prog.size() + IMEM_DEPTH + RESET_CYCLES + 4;
        run_model();
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // Whole memory rewritten so no older program is left behind
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem_we_i    <= 1'b1;
            imem_addr_i  <= IMEM_AW'(i);
            imem_wdata_i <= (i < prog.size()) ? prog[i] : '0;
            @(posedge clk);
        end
        imem_we_i <= 1'b0;
        rst_n     <= 1'b0;
        idx = 0;
        while (idx < exp_rd.size()) begin
            @(negedge clk);
            if (wb_valid_o) begin
                check_equal({name, " rd"}, 32'(exp_rd[idx]), 32'(wb_rd_o));
                check_equal({name, " data"}, exp_data[idx], wb_data_o);
                idx++;
            end
        end
        repeat (10) begin
            @(negedge clk);
            check_equal({name, " extra retire"}, 32'd0, 32'(wb_valid_o));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_alu_independent();
        prog.delete();
        prog.push_back(add_imm(1, 0, take_bits(12)));
        prog.push_back(add_imm(2, 0, take_bits(12)));
        prog.push_back(add_imm(3, 0, -7));
        prog.push_back(add_imm(4, 0, 3));
        // Three bubbles so the ALU ops read settled registers
        repeat (3) prog.push_back(32'h0);
        for (int k = 0; k < 5; k++) begin
            prog.push_back(reg_op(k, 5 + k, 1, 2));
        end
        prog.push_back(reg_op(5, 10, 3, 4));
        prog.push_back(reg_op(5, 11, 4, 3));
        prog.push_back(reg_op(5, 12, 3, 1));
        prog.push_back(add_imm(13, 3, -100));
        run_program("alu_independent");
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(add_imm(1, 0, take_bits(12)));
        prog.push_back(reg_op(0, 2, 1, 1));
        prog.push_back(reg_op(1, 3, 2, 1));
        prog.push_back(reg_op(4, 4, 3, 2));
        prog.push_back(reg_op(3, 5, 4, 1));
        prog.push_back(reg_op(2, 6, 5, 3));
        prog.push_back(reg_op(5, 7, 6, 5));
        prog.push_back(add_imm(8, 7, take_bits(12)));
        prog.push_back(reg_op(0, 9, 8, 8));
        run_program("forwarding");
    endtask

    task automatic test_load_store();
        prog.delete();
        prog.push_back(add_imm(1, 0, take_bits(12)));
        prog.push_back(add_imm(2, 0, 64));
        prog.push_back(store_word(1, 2, 0));
        prog.push_back(load_word(3, 2, 0));
        prog.push_back(reg_op(0, 4, 3, 3));
        prog.push_back(store_word(4, 2, 8));
        prog.push_back(load_word(5, 2, 8));
        prog.push_back(add_imm(6, 5, 1));
        prog.push_back(load_word(7, 2, 0));
        prog.push_back(32'h0);
        prog.push_back(reg_op(1, 8, 7, 5));
        prog.push_back(load_word(9, 2, 8));
        prog.push_back(store_word(9, 2, 12));
        prog.push_back(load_word(10, 2, 12));
        run_program("load_store");
    endtask

    task automatic test_branch();
        prog.delete();
        prog.push_back(add_imm(1, 0, 5));
        prog.push_back(add_imm(2, 0, 5));
        prog.push_back(add_imm(3, 0, 7));
        prog.push_back(branch_eq(1, 2, 12));
        prog.push_back(add_imm(4, 0, 1));
        prog.push_back(add_imm(5, 0, 2));
        prog.push_back(add_imm(6, 0, 3));
        prog.push_back(branch_eq(1, 3, 12));
        prog.push_back(add_imm(7, 0, 4));
        prog.push_back(add_imm(8, 0, 5));
        prog.push_back(add_imm(9, 0, 6));
        prog.push_back(branch_eq(0, 0, 16));
        prog.push_back(add_imm(10, 0, 7));
        prog.push_back(add_imm(11, 0, 8));
        prog.push_back(add_imm(12, 0, 9));
        prog.push_back(add_imm(13, 0, 10));
        run_program("branch");
    endtask

    task automatic test_zero_register();
        prog.delete();
        prog.push_back(add_imm(0, 0, 123));
        prog.push_back(reg_op(0, 1, 0, 0));
        prog.push_back(add_imm(2, 0, -1));
        prog.push_back(reg_op(0, 0, 2, 2));
        prog.push_back(reg_op(0, 3, 0, 2));
        prog.push_back(store_word(2, 0, 0));
        prog.push_back(load_word(0, 0, 0));
        prog.push_back(reg_op(0, 4, 0, 0));
        run_program("zero_register");
    endtask

    // Registers limited to x0..x7 for dense dependencies
    task automatic test_random_alu();
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            prog.push_back(add_imm(r, 0, take_bits(12)));
        end
        for (int k = 0; k < 40; k++) begin
            prog.push_back(reg_op(take_bits(3) % 6, take_bits(3), take_bits(3), take_bits(3)));
        end
        run_program("random_alu");
    endtask

    // Watchdog whose budget grows as each test starts
    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", budget);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        lfsr_q       = 16'd48435;
        budget       = 0;
        test_alu_independent();
        test_forwarding();
        test_load_store();
        test_branch();
        test_zero_register();
        test_random_alu();
        $display("NO ERRORS");
        $finish;
    end

endmodule
